/* include/bank_store_defs.svh */
`ifndef BANK_STORE_DEFS_SVH
`define BANK_STORE_DEFS_SVH

// ram geometry, one 8k x 8 block per bank
`define BS_ADDR_W 13
`define BS_DATA_W 8
`define BS_DEPTH 8192

// host bank select
`define BS_BANK_W 2
`define BS_NUM_BANKS 4

`endif

/* src/bank_store_pkg.sv */
`default_nettype none

`include "bank_store_defs.svh"

package bank_store_pkg;

    // host-side bank select, order fixed by the host protocol
    typedef enum logic [`BS_BANK_W-1:0] {
        BANK_SRC = 0,
        BANK_KEY = 1,
        BANK_CMD = 2,
        BANK_DST = 3
    } bank_e;

    // writer sequencer, each name is the condition just registered
    typedef enum logic [2:0] {
        W_IDLE, W_SETUP, W_CLK_HI, W_CLK_LO, W_CLEANUP, W_ADVANCE, W_WAIT_LOW
    } write_state_e;

    // reader sequencer, one extra capture step
    typedef enum logic [2:0] {
        R_IDLE, R_SETUP, R_CLK_HI, R_CLK_LO, R_CAPTURE, R_CLEANUP, R_ADVANCE, R_WAIT_LOW
    } read_state_e;

endpackage

`default_nettype wire

/* src/block_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_store_defs.svh"

// simple dual-port block ram model
// port a write only, port b registered read
module block_ram (
    input  wire                   wr_clk,  // sequencer-generated, not sysclk
    input  wire                   wr_ce,
    input  wire                   wr_wre,
    input  wire [`BS_ADDR_W-1:0]  wr_ad,
    input  wire [`BS_DATA_W-1:0]  wr_din,
    input  wire                   rd_clk,
    input  wire                   rd_ce,
    input  wire                   rd_oce,  // output register enable
    input  wire [`BS_ADDR_W-1:0]  rd_ad,
    output logic [`BS_DATA_W-1:0] rd_dout
);

    logic [`BS_DATA_W-1:0] mem [`BS_DEPTH];  // contents survive reset

    // port a
    always_ff @(posedge wr_clk) begin
        if (wr_ce && wr_wre) begin
            mem[wr_ad] <= wr_din;
        end
    end

    // port b, dout only moves on an enabled read
    always_ff @(posedge rd_clk) begin
        if (rd_ce && rd_oce) begin
            rd_dout <= mem[rd_ad];
        end
    end

endmodule

`default_nettype wire

/* src/bank_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_store_defs.svh"

// turns one strobe level into one ram write
// ram_clk is toggled from sysclk, so one ram edge per strobe
module bank_writer (
    input  wire                   sysclk,
    input  wire                   external_reset,
    input  wire                   strobe,   // per-bank write level from top demux
    input  wire [`BS_DATA_W-1:0]  data_in,
    output logic [`BS_ADDR_W-1:0] ram_ad,
    output logic [`BS_DATA_W-1:0] ram_din,
    output logic                  ram_ce,
    output logic                  ram_wre,
    output logic                  ram_clk
);

    bank_store_pkg::write_state_e state;
    logic [`BS_ADDR_W-1:0]        wr_ptr;  // next address to write

    // sequencer and ram strobes
    always_ff @(posedge sysclk) begin
        if (external_reset) begin
            state   <= bank_store_pkg::W_IDLE;
            wr_ptr  <= '0;
            ram_ce  <= 1'b0;
            ram_wre <= 1'b0;
            ram_clk <= 1'b0;
        end else begin
            case (state)
                bank_store_pkg::W_IDLE: begin
                    if (strobe) begin  // cycle 1, enables up with addr/data
                        ram_ce  <= 1'b1;
                        ram_wre <= 1'b1;
                        state   <= bank_store_pkg::W_SETUP;
                    end
                end
                bank_store_pkg::W_SETUP: begin
                    ram_clk <= 1'b1;  // ram writes here
                    state   <= bank_store_pkg::W_CLK_HI;
                end
                bank_store_pkg::W_CLK_HI: begin
                    ram_clk <= 1'b0;
                    state   <= bank_store_pkg::W_CLK_LO;
                end
                bank_store_pkg::W_CLK_LO: begin
                    ram_ce  <= 1'b0;  // release enables
                    ram_wre <= 1'b0;
                    state   <= bank_store_pkg::W_CLEANUP;
                end
                bank_store_pkg::W_CLEANUP: begin
                    wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
                    state  <= bank_store_pkg::W_ADVANCE;
                end
                bank_store_pkg::W_ADVANCE: begin
                    state <= bank_store_pkg::W_WAIT_LOW;
                end
                bank_store_pkg::W_WAIT_LOW: begin
                    // long strobe just parks here
                    if (!strobe) state <= bank_store_pkg::W_IDLE;
                end
                default: begin
                    state   <= bank_store_pkg::W_IDLE;
                    ram_ce  <= 1'b0;
                    ram_wre <= 1'b0;
                    ram_clk <= 1'b0;
                end
            endcase
        end
    end

    // address and data latched with the enables, held for the whole cycle
    always_ff @(posedge sysclk) begin
        if (state == bank_store_pkg::W_IDLE && strobe) begin
            ram_ad  <= wr_ptr;
            ram_din <= data_in;
        end
    end

endmodule

`default_nettype wire

/* src/bank_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_store_defs.svh"

// one ram read per strobe level, byte lands in read_data
module bank_reader (
    input  wire                   sysclk,
    input  wire                   external_reset,
    input  wire                   strobe,   // per-bank read level from top demux
    input  wire [`BS_DATA_W-1:0]  ram_dout,
    output logic [`BS_ADDR_W-1:0] ram_ad,
    output logic                  ram_ce,
    output logic                  ram_oce,
    output logic                  ram_clk,
    output logic [`BS_DATA_W-1:0] read_data  // held until next read of this bank
);

    bank_store_pkg::read_state_e state;
    logic [`BS_ADDR_W-1:0]       rd_ptr;  // next address to read

    always_ff @(posedge sysclk) begin
        if (external_reset) begin
            state     <= bank_store_pkg::R_IDLE;
            rd_ptr    <= '0;
            ram_ce    <= 1'b0;
            ram_oce   <= 1'b0;
            ram_clk   <= 1'b0;
            read_data <= '0;
        end else begin
            case (state)
                bank_store_pkg::R_IDLE: begin
                    if (strobe) begin  // cycle 1
                        ram_ce  <= 1'b1;
                        ram_oce <= 1'b1;
                        state   <= bank_store_pkg::R_SETUP;
                    end
                end
                bank_store_pkg::R_SETUP: begin
                    ram_clk <= 1'b1;  // ram registers dout on this rise
                    state   <= bank_store_pkg::R_CLK_HI;
                end
                bank_store_pkg::R_CLK_HI: begin
                    ram_clk <= 1'b0;
                    state   <= bank_store_pkg::R_CLK_LO;
                end
                bank_store_pkg::R_CLK_LO: begin
                    read_data <= ram_dout;  // settled two edges after rd_clk rise
                    state     <= bank_store_pkg::R_CAPTURE;
                end
                bank_store_pkg::R_CAPTURE: begin
                    ram_ce  <= 1'b0;
                    ram_oce <= 1'b0;
                    state   <= bank_store_pkg::R_CLEANUP;
                end
                bank_store_pkg::R_CLEANUP: begin
                    rd_ptr <= rd_ptr + 1'b1;  // same wrap as writer
                    state  <= bank_store_pkg::R_ADVANCE;
                end
                bank_store_pkg::R_ADVANCE: begin
                    state <= bank_store_pkg::R_WAIT_LOW;
                end
                bank_store_pkg::R_WAIT_LOW: begin
                    if (!strobe) state <= bank_store_pkg::R_IDLE;
                end
                default: begin
                    state   <= bank_store_pkg::R_IDLE;
                    ram_ce  <= 1'b0;
                    ram_oce <= 1'b0;
                    ram_clk <= 1'b0;
                end
            endcase
        end
    end

    // address presented with the enables
    always_ff @(posedge sysclk) begin
        if (state == bank_store_pkg::R_IDLE && strobe) begin
            ram_ad <= rd_ptr;
        end
    end

endmodule

`default_nettype wire

/* src/bank_store_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_store_defs.svh"

// four-bank byte store for a strobe-driven host
module bank_store_top (
    input  wire                    sysclk,
    input  wire                    external_reset,
    input  wire [`BS_DATA_W-1:0]   external_data_in,
    output logic [`BS_DATA_W-1:0]  external_data_out,
    input  wire bank_store_pkg::bank_e external_data_bank,
    input  wire                    external_data_clock,  // host strobe, level only
    input  wire                    external_read         // 1 read, 0 write
);

    logic [`BS_DATA_W-1:0] read_data [`BS_NUM_BANKS];  // per-bank output registers

    for (genvar i = 0; i < `BS_NUM_BANKS; i++) begin : g_bank
        logic                  wr_strobe, rd_strobe;
        logic [`BS_ADDR_W-1:0] wr_ad, rd_ad;
        logic [`BS_DATA_W-1:0] wr_din, rd_dout;
        logic                  wr_ce, wr_wre, wr_clk;
        logic                  rd_ce, rd_oce, rd_clk;
        logic                  bank_hit;

        // strobe demux, by bank then direction
        assign bank_hit  = (external_data_bank == bank_store_pkg::bank_e'(i));
        assign wr_strobe = external_data_clock && bank_hit && !external_read;
        assign rd_strobe = external_data_clock && bank_hit && external_read;

        bank_writer writer_i (
            .sysclk         (sysclk),
            .external_reset (external_reset),
            .strobe         (wr_strobe),
            .data_in        (external_data_in),  // shared host bus
            .ram_ad         (wr_ad),
            .ram_din        (wr_din),
            .ram_ce         (wr_ce),
            .ram_wre        (wr_wre),
            .ram_clk        (wr_clk)
        );

        bank_reader reader_i (
            .sysclk         (sysclk),
            .external_reset (external_reset),
            .strobe         (rd_strobe),
            .ram_dout       (rd_dout),
            .ram_ad         (rd_ad),
            .ram_ce         (rd_ce),
            .ram_oce        (rd_oce),
            .ram_clk        (rd_clk),
            .read_data      (read_data[i])
        );

        block_ram ram_i (
            .wr_clk  (wr_clk),
            .wr_ce   (wr_ce),
            .wr_wre  (wr_wre),
            .wr_ad   (wr_ad),
            .wr_din  (wr_din),
            .rd_clk  (rd_clk),
            .rd_ce   (rd_ce),
            .rd_oce  (rd_oce),
            .rd_ad   (rd_ad),
            .rd_dout (rd_dout)
        );
    end

    // output follows bank select, no extra register
    assign external_data_out = read_data[external_data_bank];

endmodule

`default_nettype wire

/* dv/bank_store_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// rules shared by the writer and reader ram strobes
// ram_en is wre on the writer, oce on the reader
module bank_store_sva (
    input wire sysclk,
    input wire external_reset,
    input wire ram_ce,
    input wire ram_en,
    input wire ram_clk
);

    // enable only inside a chip-enable window
    en_needs_ce: assert property (@(posedge sysclk) disable iff (external_reset)
        ram_en |-> ram_ce)
        else $error("ram enable high without chip enable");

    clk_within_ce: assert property (@(posedge sysclk) disable iff (external_reset)
        ram_clk |-> ram_ce)
        else $error("ram clock high outside chip enable");

    // single pulse per access
    clk_single_pulse: assert property (@(posedge sysclk) disable iff (external_reset)
        ram_clk |=> !ram_clk)
        else $error("ram clock high for two cycles");

    strobes_low_after_reset: assert property (@(posedge sysclk)
        external_reset |=> (!ram_ce && !ram_en && !ram_clk))
        else $error("ram strobe high after reset");

endmodule

bind bank_writer bank_store_sva writer_sva_i (
    .sysclk         (sysclk),
    .external_reset (external_reset),
    .ram_ce         (ram_ce),
    .ram_en         (ram_wre),
    .ram_clk        (ram_clk)
);

bind bank_reader bank_store_sva reader_sva_i (
    .sysclk         (sysclk),
    .external_reset (external_reset),
    .ram_ce         (ram_ce),
    .ram_en         (ram_oce),
    .ram_clk        (ram_clk)
);

`default_nettype wire

/* dv/bank_store_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_store_defs.svh"

module bank_store_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int STROBE_HI   = 10;  // host strobe high in sysclk cycles
    localparam int STROBE_LO   = 4;
    localparam int RANDOM_OPS  = 200;
    localparam int TOTAL_OPS   = 16 + 48 + 14 + RANDOM_OPS + 2 + 12;  // directed + random + reset ops
    localparam logic [31:0] SEED = 32'h566f_fbef;
    localparam longint TIMEOUT_NS = 2 * TOTAL_OPS * (STROBE_HI + STROBE_LO) * CLK_PERIOD;

    logic                  sysclk;
    logic                  external_reset;
    logic [`BS_DATA_W-1:0] external_data_in;
    logic [`BS_DATA_W-1:0] external_data_out;
    bank_store_pkg::bank_e external_data_bank;
    logic                  external_data_clock;
    logic                  external_read;

    logic [`BS_DATA_W-1:0] model_mem [`BS_NUM_BANKS][`BS_DEPTH];  // reference contents
    int                    wr_ptr_m [`BS_NUM_BANKS];
    int                    rd_ptr_m [`BS_NUM_BANKS];
    int                    valid_cnt [`BS_NUM_BANKS];  // addresses ever written
    logic [`BS_DATA_W-1:0] exp_q [$];  // expected bytes in read order
    int                    exp_bank_q [$];
    logic [31:0]           lfsr_state;
    int                    errors;

    bank_store_top dut_i (
        .sysclk              (sysclk),
        .external_reset      (external_reset),
        .external_data_in    (external_data_in),
        .external_data_out   (external_data_out),
        .external_data_bank  (external_data_bank),
        .external_data_clock (external_data_clock),
        .external_read       (external_read)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) s = s ^ 32'hA300_0000;
        return s;
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // model byte at the read pointer, then the pointer moves on
    function automatic logic [`BS_DATA_W-1:0] expected_read(input int bank);
        logic [`BS_DATA_W-1:0] v;
        v = model_mem[bank][rd_ptr_m[bank]];
        rd_ptr_m[bank] = (rd_ptr_m[bank] + 1) % `BS_DEPTH;
        return v;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one host access with strobe high then low
    task automatic host_op(input int bank, input logic rd, input logic [`BS_DATA_W-1:0] data);
        @(posedge sysclk);
        external_data_bank  <= bank_store_pkg::bank_e'(bank);
        external_read       <= rd;
        external_data_in    <= data;
        external_data_clock <= 1'b1;
        repeat (STROBE_HI) @(posedge sysclk);
        external_data_clock <= 1'b0;
        repeat (STROBE_LO - 1) @(posedge sysclk);  // last low cycle is the next op's edge
    endtask

    task automatic write_byte(input int bank, input logic [`BS_DATA_W-1:0] data);
        model_mem[bank][wr_ptr_m[bank]] = data;
        wr_ptr_m[bank] = (wr_ptr_m[bank] + 1) % `BS_DEPTH;
        if (wr_ptr_m[bank] > valid_cnt[bank]) valid_cnt[bank] = wr_ptr_m[bank];
        host_op(bank, 1'b0, data);
    endtask

    task automatic read_byte(input int bank);
        exp_q.push_back(expected_read(bank));  // queued before the strobe
        exp_bank_q.push_back(bank);
        host_op(bank, 1'b1, 8'h00);
    endtask

    task automatic pulse_reset();
        external_reset <= 1'b1;
        repeat (3) @(posedge sysclk);
        external_reset <= 1'b0;
        for (int b = 0; b < `BS_NUM_BANKS; b++) begin
            wr_ptr_m[b] = 0;  // memory model kept
            rd_ptr_m[b] = 0;
        end
    endtask

    task automatic check_idle_outputs();
        for (int b = 0; b < `BS_NUM_BANKS; b++) begin
            @(posedge sysclk);
            external_data_bank <= bank_store_pkg::bank_e'(b);
            @(negedge sysclk);
            check_value(external_data_out, 0, $sformatf("output after reset, bank %0d", b));
        end
    endtask

    // compare mid-cycle two cycles after a read strobe falls
    initial begin : compare_reads
        logic [`BS_DATA_W-1:0] exp;
        int                    bank;
        forever begin
            @(negedge external_data_clock);
            if (external_read === 1'b1 && exp_q.size() > 0) begin
                exp  = exp_q[0];
                bank = exp_bank_q[0];
                repeat (2) @(posedge sysclk);
                @(negedge sysclk);
                check_value(external_data_out, exp, $sformatf("read data, bank %0d", bank));
                exp_q.delete(0);  // retired only once compared
                exp_bank_q.delete(0);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the test sequence in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int rd_sel;
        int bank;
        sysclk              = 1'b0;
        lfsr_state          = SEED;
        errors              = 0;
        external_data_in    <= '0;
        external_data_bank  <= bank_store_pkg::BANK_SRC;
        external_data_clock <= 1'b0;
        external_read       <= 1'b0;
        for (int b = 0; b < `BS_NUM_BANKS; b++) valid_cnt[b] = 0;
        pulse_reset();
        check_idle_outputs();  // outputs cleared by reset

        // single bank write then read back in order
        for (int i = 0; i < 8; i++) write_byte(0, random_bits(8));
        for (int i = 0; i < 8; i++) read_byte(0);

        // interleaved writes across banks then per-bank reads
        for (int i = 0; i < 6; i++) begin
            for (int b = 0; b < `BS_NUM_BANKS; b++) write_byte(b, random_bits(8));
        end
        for (int b = 0; b < `BS_NUM_BANKS; b++) begin
            for (int i = 0; i < 6; i++) read_byte(b);
        end

        // read pointer independent of write pointer on the cmd bank
        for (int i = 0; i < 4; i++) write_byte(2, random_bits(8));
        for (int i = 0; i < 2; i++) read_byte(2);
        for (int i = 0; i < 3; i++) write_byte(2, random_bits(8));
        for (int i = 0; i < 5; i++) read_byte(2);

        // random mix with reads only where unread data exists
        for (int n = 0; n < RANDOM_OPS; n++) begin
            bank   = random_bits(2);
            rd_sel = random_bits(1);
            if (rd_sel == 1 && rd_ptr_m[bank] < wr_ptr_m[bank]) read_byte(bank);
            else write_byte(bank, random_bits(8));
        end

        // mid-run reset keeps contents and clears both pointers
        pulse_reset();
        check_idle_outputs();
        for (int i = 0; i < 2; i++) write_byte(3, random_bits(8));  // overwrites dst from 0
        for (int b = 0; b < `BS_NUM_BANKS; b++) begin
            for (int i = 0; i < 3 && i < valid_cnt[b]; i++) read_byte(b);
        end

        repeat (STROBE_LO) @(posedge sysclk);  // last compare done
        check_value(exp_q.size(), 0, "reads left unchecked");
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
src/bank_store_pkg.sv
src/block_ram.sv
src/bank_writer.sv
src/bank_reader.sv
src/bank_store_top.sv
dv/bank_store_sva.sv
dv/bank_store_tb.sv
